// ==== hw/ex_defines.svh ====
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data path word width
`define EX_XLEN 32

// Register file address width
`define EX_RADDR_W 5

// Load forwarding slots from the memory stage
// Highest index is the newest
`define EX_FWD_SLOTS 2

`endif

// ==== hw/ex_op_pkg.sv ====
`default_nettype none

package ex_op_pkg;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_ORN,
        OP_ANDN,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_PCADDU12I,
        OP_B,
        OP_BL,
        OP_JIRL,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LD_B,
        OP_LD_H,
        OP_LD_W,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W
    } ex_op_t;

    // Source of the register write data
    typedef enum logic [2:0] {
        RES_LOGIC,
        RES_SHIFT,
        RES_ARITH,
        RES_MOVE,
        RES_LINK,
        RES_MEM,
        RES_NONE
    } res_class_t;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_t;

endpackage

`default_nettype wire

// ==== hw/ex_data_pkg.sv ====
`default_nettype none

`include "ex_defines.svh"

package ex_data_pkg;

    typedef logic [`EX_XLEN-1:0] word_t;

    // Register 0 is not special in this stage
    typedef logic [`EX_RADDR_W-1:0] reg_addr_t;

    typedef logic [1:0] excp_code_t;

    localparam excp_code_t EXCP_NONE = 2'd0;
    // Address misaligned
    localparam excp_code_t EXCP_ALE = 2'd1;

endpackage

`default_nettype wire

// ==== hw/ex_decode.sv ====
`default_nettype none

`include "ex_defines.svh"

module ex_decode (
    input  ex_op_pkg::ex_op_t                          op_i,
    input  ex_data_pkg::reg_addr_t                     rs1_addr_i,
    input  ex_data_pkg::reg_addr_t                     rs2_addr_i,
    input  ex_data_pkg::word_t                         rs1_data_i,
    input  ex_data_pkg::word_t                         rs2_data_i,
    input  ex_data_pkg::word_t                         imm_i,
    input  logic                                       use_imm_i,
    input  logic [`EX_FWD_SLOTS-1:0]                   fwd_we_i,
    input  ex_data_pkg::reg_addr_t [`EX_FWD_SLOTS-1:0] fwd_addr_i,
    input  ex_data_pkg::word_t [`EX_FWD_SLOTS-1:0]     fwd_data_i,
    output ex_data_pkg::word_t                         op_a_o,
    output ex_data_pkg::word_t                         op_b_o,
    output ex_data_pkg::word_t                         reg_b_o,
    output ex_op_pkg::res_class_t                      res_class_o,
    output ex_op_pkg::mem_size_t                       mem_size_o,
    output logic                                       is_load_o,
    output logic                                       is_store_o
);
    import ex_op_pkg::*;
    import ex_data_pkg::*;

    // Later slots override earlier ones, so the newest match wins
    function automatic word_t fwd_select(reg_addr_t addr, word_t base);
        word_t val;
        val = base;
        for (int i = 0; i < `EX_FWD_SLOTS; i++) begin
            if (fwd_we_i[i] && fwd_addr_i[i] == addr) begin
                val = fwd_data_i[i];
            end
        end
        return val;
    endfunction

    always_comb begin
        op_a_o  = fwd_select(rs1_addr_i, rs1_data_i);
        reg_b_o = fwd_select(rs2_addr_i, rs2_data_i);
        op_b_o  = use_imm_i ? imm_i : reg_b_o;
    end

    always_comb begin
        case (op_i)
            OP_AND, OP_OR, OP_XOR, OP_NOR, OP_ORN, OP_ANDN: res_class_o = RES_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:                         res_class_o = RES_SHIFT;
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU:                res_class_o = RES_ARITH;
            OP_LUI, OP_PCADDU12I:                           res_class_o = RES_MOVE;
            OP_BL, OP_JIRL:                                 res_class_o = RES_LINK;
            OP_LD_B, OP_LD_H, OP_LD_W:                      res_class_o = RES_MEM;
            OP_ST_B, OP_ST_H, OP_ST_W:                      res_class_o = RES_MEM;
            default:                                        res_class_o = RES_NONE;
        endcase
    end

    // Access kind and size
    always_comb begin
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        mem_size_o = MEM_WORD;
        case (op_i)
            OP_LD_B, OP_ST_B: mem_size_o = MEM_BYTE;
            OP_LD_H, OP_ST_H: mem_size_o = MEM_HALF;
            default:          mem_size_o = MEM_WORD;
        endcase
        if (op_i == OP_LD_B || op_i == OP_LD_H || op_i == OP_LD_W) begin
            is_load_o = 1'b1;
        end
        if (op_i == OP_ST_B || op_i == OP_ST_H || op_i == OP_ST_W) begin
            is_store_o = 1'b1;
        end
    end

    a_mem_class: assert final (!(is_load_o || is_store_o) || res_class_o == RES_MEM);

endmodule

`default_nettype wire

// ==== hw/ex_alu.sv ====
`default_nettype none

`include "ex_defines.svh"

module ex_alu (
    input  ex_op_pkg::ex_op_t  op_i,
    input  ex_data_pkg::word_t op_a_i,
    input  ex_data_pkg::word_t op_b_i,
    input  ex_data_pkg::word_t reg_b_i,
    input  ex_data_pkg::word_t imm_i,
    input  ex_data_pkg::word_t pc_i,
    output ex_data_pkg::word_t logic_o,
    output ex_data_pkg::word_t shift_o,
    output ex_data_pkg::word_t arith_o,
    output ex_data_pkg::word_t move_o,
    output ex_data_pkg::word_t link_o,
    output ex_data_pkg::word_t mem_addr_o,
    output ex_data_pkg::word_t branch_target_o,
    output logic               branch_taken_o
);
    import ex_op_pkg::*;
    import ex_data_pkg::*;

    logic [$clog2(`EX_XLEN)-1:0] shamt;
    word_t                       pc_imm;
    logic                        br_lt_s;
    logic                        br_lt_u;

    assign shamt      = op_b_i[$clog2(`EX_XLEN)-1:0];
    assign pc_imm     = pc_i + imm_i;
    assign mem_addr_o = op_a_i + imm_i;
    assign link_o     = pc_i + word_t'(4);

    // Branch compares use the register values, never the immediate
    assign br_lt_s = $signed(op_a_i) < $signed(reg_b_i);
    assign br_lt_u = op_a_i < reg_b_i;

    always_comb begin
        case (op_i)
            OP_AND:  logic_o = op_a_i & op_b_i;
            OP_OR:   logic_o = op_a_i | op_b_i;
            OP_XOR:  logic_o = op_a_i ^ op_b_i;
            OP_NOR:  logic_o = ~(op_a_i | op_b_i);
            OP_ORN:  logic_o = op_a_i | ~op_b_i;
            OP_ANDN: logic_o = op_a_i & ~op_b_i;
            default: logic_o = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            OP_SLL:  shift_o = op_a_i << shamt;
            OP_SRL:  shift_o = op_a_i >> shamt;
            OP_SRA:  shift_o = word_t'($signed(op_a_i) >>> shamt);
            default: shift_o = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            OP_ADD:  arith_o = op_a_i + op_b_i;
            OP_SUB:  arith_o = op_a_i - op_b_i;
            OP_SLT:  arith_o = word_t'($signed(op_a_i) < $signed(op_b_i));
            OP_SLTU: arith_o = word_t'(op_a_i < op_b_i);
            default: arith_o = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            OP_LUI:       move_o = op_b_i;
            OP_PCADDU12I: move_o = pc_i + op_b_i;
            default:      move_o = '0;
        endcase
    end

    always_comb begin
        branch_taken_o  = 1'b0;
        branch_target_o = pc_imm;
        case (op_i)
            OP_B, OP_BL: branch_taken_o = 1'b1;
            OP_JIRL: begin
                branch_taken_o  = 1'b1;
                branch_target_o = op_a_i + imm_i;
            end
            OP_BEQ:  branch_taken_o = op_a_i == reg_b_i;
            OP_BNE:  branch_taken_o = op_a_i != reg_b_i;
            OP_BLT:  branch_taken_o = br_lt_s;
            OP_BGE:  branch_taken_o = !br_lt_s;
            OP_BLTU: branch_taken_o = br_lt_u;
            OP_BGEU: branch_taken_o = !br_lt_u;
            // Not a control transfer
            default: branch_target_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/ex_result.sv ====
`default_nettype none

module ex_result (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic                   valid_i,
    input  ex_op_pkg::res_class_t  res_class_i,
    input  ex_op_pkg::mem_size_t   mem_size_i,
    input  logic                   is_load_i,
    input  logic                   is_store_i,
    input  ex_data_pkg::word_t     logic_i,
    input  ex_data_pkg::word_t     shift_i,
    input  ex_data_pkg::word_t     arith_i,
    input  ex_data_pkg::word_t     move_i,
    input  ex_data_pkg::word_t     link_i,
    input  ex_data_pkg::word_t     mem_addr_i,
    input  ex_data_pkg::word_t     store_data_i,
    input  ex_data_pkg::reg_addr_t rd_addr_i,
    input  logic                   rd_we_i,
    output logic                   valid_o,
    output logic                   rd_we_o,
    output ex_data_pkg::reg_addr_t rd_addr_o,
    output ex_data_pkg::word_t     rd_data_o,
    output ex_data_pkg::word_t     mem_addr_o,
    output ex_data_pkg::word_t     store_data_o,
    output logic                   is_load_o,
    output logic                   is_store_o,
    output logic                   excp_o,
    output ex_data_pkg::excp_code_t excp_code_o
);
    import ex_op_pkg::*;
    import ex_data_pkg::*;

    word_t wdata;
    logic  misaligned;
    logic  wr_en;

    // Loads, stores and branches carry no write data here
    always_comb begin
        case (res_class_i)
            RES_LOGIC: wdata = logic_i;
            RES_SHIFT: wdata = shift_i;
            RES_ARITH: wdata = arith_i;
            RES_MOVE:  wdata = move_i;
            RES_LINK:  wdata = link_i;
            default:   wdata = '0;
        endcase
    end

    always_comb begin
        misaligned = 1'b0;
        if (res_class_i == RES_MEM) begin
            case (mem_size_i)
                MEM_HALF: misaligned = mem_addr_i[0];
                MEM_WORD: misaligned = |mem_addr_i[1:0];
                default:  misaligned = 1'b0;
            endcase
        end
    end

    assign wr_en = valid_i && rd_we_i && res_class_i != RES_NONE && !misaligned;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_o    <= 1'b0;
            rd_we_o    <= 1'b0;
            is_load_o  <= 1'b0;
            is_store_o <= 1'b0;
            excp_o     <= 1'b0;
        end else if (!stall_i) begin
            valid_o    <= valid_i;
            rd_we_o    <= wr_en;
            is_load_o  <= valid_i && is_load_i;
            is_store_o <= valid_i && is_store_i;
            excp_o     <= valid_i && misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            rd_addr_o    <= rd_addr_i;
            rd_data_o    <= wdata;
            mem_addr_o   <= mem_addr_i;
            store_data_o <= store_data_i;
            excp_code_o  <= misaligned ? EXCP_ALE : EXCP_NONE;
        end
    end

    a_flush_empties: assert property (
        @(posedge clk) disable iff (reset_i) flush_i |=> !valid_o);

    a_excp_has_valid: assert property (
        @(posedge clk) disable iff (reset_i) excp_o |-> valid_o);

endmodule

`default_nettype wire

// ==== hw/ex_stage.sv ====
`default_nettype none

`include "ex_defines.svh"

module ex_stage (
    input  logic                                       clk,
    input  logic                                       reset_i,
    input  logic                                       valid_i,
    input  ex_op_pkg::ex_op_t                          op_i,
    input  logic                                       use_imm_i,
    input  ex_data_pkg::reg_addr_t                     rs1_addr_i,
    input  ex_data_pkg::reg_addr_t                     rs2_addr_i,
    input  ex_data_pkg::word_t                         rs1_data_i,
    input  ex_data_pkg::word_t                         rs2_data_i,
    input  ex_data_pkg::word_t                         imm_i,
    input  ex_data_pkg::word_t                         pc_i,
    input  ex_data_pkg::reg_addr_t                     rd_addr_i,
    input  logic                                       rd_we_i,
    input  logic [`EX_FWD_SLOTS-1:0]                   fwd_we_i,
    input  ex_data_pkg::reg_addr_t [`EX_FWD_SLOTS-1:0] fwd_addr_i,
    input  ex_data_pkg::word_t [`EX_FWD_SLOTS-1:0]     fwd_data_i,
    input  logic                                       stall_i,
    input  logic                                       flush_i,
    output logic                                       branch_taken_o,
    output ex_data_pkg::word_t                         branch_target_o,
    output logic                                       valid_o,
    output logic                                       rd_we_o,
    output ex_data_pkg::reg_addr_t                     rd_addr_o,
    output ex_data_pkg::word_t                         rd_data_o,
    output ex_data_pkg::word_t                         mem_addr_o,
    output ex_data_pkg::word_t                         store_data_o,
    output logic                                       is_load_o,
    output logic                                       is_store_o,
    output logic                                       excp_o,
    output ex_data_pkg::excp_code_t                    excp_code_o
);
    import ex_op_pkg::*;
    import ex_data_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      reg_b;
    res_class_t res_class;
    mem_size_t  mem_size;
    logic       is_load;
    logic       is_store;
    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;
    word_t      move_res;
    word_t      link_res;
    word_t      mem_addr;
    word_t      alu_target;
    logic       alu_taken;

    ex_decode u_decode (
        .op_i        (op_i),
        .rs1_addr_i  (rs1_addr_i),
        .rs2_addr_i  (rs2_addr_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .imm_i       (imm_i),
        .use_imm_i   (use_imm_i),
        .fwd_we_i    (fwd_we_i),
        .fwd_addr_i  (fwd_addr_i),
        .fwd_data_i  (fwd_data_i),
        .op_a_o      (op_a),
        .op_b_o      (op_b),
        .reg_b_o     (reg_b),
        .res_class_o (res_class),
        .mem_size_o  (mem_size),
        .is_load_o   (is_load),
        .is_store_o  (is_store)
    );

    ex_alu u_alu (
        .op_i            (op_i),
        .op_a_i          (op_a),
        .op_b_i          (op_b),
        .reg_b_i         (reg_b),
        .imm_i           (imm_i),
        .pc_i            (pc_i),
        .logic_o         (logic_res),
        .shift_o         (shift_res),
        .arith_o         (arith_res),
        .move_o          (move_res),
        .link_o          (link_res),
        .mem_addr_o      (mem_addr),
        .branch_target_o (alu_target),
        .branch_taken_o  (alu_taken)
    );

    // Redirect goes to fetch in the same cycle
    assign branch_taken_o  = valid_i && alu_taken;
    assign branch_target_o = valid_i ? alu_target : '0;

    ex_result u_result (
        .clk          (clk),
        .reset_i      (reset_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .valid_i      (valid_i),
        .res_class_i  (res_class),
        .mem_size_i   (mem_size),
        .is_load_i    (is_load),
        .is_store_i   (is_store),
        .logic_i      (logic_res),
        .shift_i      (shift_res),
        .arith_i      (arith_res),
        .move_i       (move_res),
        .link_i       (link_res),
        .mem_addr_i   (mem_addr),
        .store_data_i (reg_b),
        .rd_addr_i    (rd_addr_i),
        .rd_we_i      (rd_we_i),
        .valid_o      (valid_o),
        .rd_we_o      (rd_we_o),
        .rd_addr_o    (rd_addr_o),
        .rd_data_o    (rd_data_o),
        .mem_addr_o   (mem_addr_o),
        .store_data_o (store_data_o),
        .is_load_o    (is_load_o),
        .is_store_o   (is_store_o),
        .excp_o       (excp_o),
        .excp_code_o  (excp_code_o)
    );

endmodule

`default_nettype wire

// ==== tests/tb_ex_stage.sv ====
`default_nettype none

`include "ex_defines.svh"

module tb_ex_stage;
    import ex_op_pkg::*;
    import ex_data_pkg::*;

    localparam int PERIOD     = 100;
    localparam int N_ALU      = 200;
    localparam int N_FWD      = 200;
    localparam int N_BRANCH   = 150;
    localparam int N_MEM      = 150;
    localparam int N_CTRL     = 200;
    localparam int WDOG_CYCLES = 3 + N_ALU + N_FWD + N_BRANCH + N_MEM + N_CTRL + 30 + 100;

    typedef struct packed {
        logic       valid;
        logic       we;
        reg_addr_t  rd_addr;
        word_t      rd_data;
        word_t      mem_addr;
        word_t      store_data;
        logic       is_load;
        logic       is_store;
        logic       excp;
        excp_code_t excp_code;
        logic       is_ctrl;
        logic       taken;
        word_t      target;
    } expect_t;

    logic                           clk = 1'b0;
    logic                           reset_i;
    logic                           valid_i;
    ex_op_t                         op_i;
    logic                           use_imm_i;
    reg_addr_t                      rs1_addr_i;
    reg_addr_t                      rs2_addr_i;
    word_t                          rs1_data_i;
    word_t                          rs2_data_i;
    word_t                          imm_i;
    word_t                          pc_i;
    reg_addr_t                      rd_addr_i;
    logic                           rd_we_i;
    logic [`EX_FWD_SLOTS-1:0]       fwd_we_i;
    reg_addr_t [`EX_FWD_SLOTS-1:0]  fwd_addr_i;
    word_t [`EX_FWD_SLOTS-1:0]      fwd_data_i;
    logic                           stall_i;
    logic                           flush_i;
    logic                           branch_taken_o;
    word_t                          branch_target_o;
    logic                           valid_o;
    logic                           rd_we_o;
    reg_addr_t                      rd_addr_o;
    word_t                          rd_data_o;
    word_t                          mem_addr_o;
    word_t                          store_data_o;
    logic                           is_load_o;
    logic                           is_store_o;
    logic                           excp_o;
    excp_code_t                     excp_code_o;

    expect_t exp_q;
    int      checks;
    int      errors;

    ex_stage DUT (.*);

    always #(PERIOD / 2) clk = ~clk;

    // Newest slot first, then the older slot, then the register file value
    function automatic word_t forward_value(reg_addr_t addr, word_t base);
        if (fwd_we_i[1] && fwd_addr_i[1] == addr) begin
            return fwd_data_i[1];
        end else if (fwd_we_i[0] && fwd_addr_i[0] == addr) begin
            return fwd_data_i[0];
        end
        return base;
    endfunction

    function automatic expect_t predict_stage();
        expect_t e;
        word_t   a;
        word_t   rb;
        word_t   b;
        logic    mis;
        logic    no_write;
        a  = forward_value(rs1_addr_i, rs1_data_i);
        rb = forward_value(rs2_addr_i, rs2_data_i);
        b  = use_imm_i ? imm_i : rb;
        e  = '0;
        case (op_i)
            OP_ADD:       e.rd_data = a + b;
            OP_SUB:       e.rd_data = a - b;
            OP_SLT:       e.rd_data = {31'b0, $signed(a) < $signed(b)};
            OP_SLTU:      e.rd_data = {31'b0, a < b};
            OP_AND:       e.rd_data = a & b;
            OP_OR:        e.rd_data = a | b;
            OP_XOR:       e.rd_data = a ^ b;
            OP_NOR:       e.rd_data = ~(a | b);
            OP_ORN:       e.rd_data = a | ~b;
            OP_ANDN:      e.rd_data = a & ~b;
            OP_SLL:       e.rd_data = a << b[4:0];
            OP_SRL:       e.rd_data = a >> b[4:0];
            OP_SRA:       e.rd_data = word_t'($signed(a) >>> b[4:0]);
            OP_LUI:       e.rd_data = b;
            OP_PCADDU12I: e.rd_data = pc_i + b;
            OP_BL:        e.rd_data = pc_i + 32'd4;
            OP_JIRL:      e.rd_data = pc_i + 32'd4;
            default:      e.rd_data = '0;
        endcase
        e.is_ctrl = op_i inside {[OP_B:OP_BGEU]};
        case (op_i)
            OP_B, OP_BL, OP_JIRL: e.taken = 1'b1;
            OP_BEQ:               e.taken = a == rb;
            OP_BNE:               e.taken = a != rb;
            OP_BLT:               e.taken = $signed(a) < $signed(rb);
            OP_BGE:               e.taken = $signed(a) >= $signed(rb);
            OP_BLTU:              e.taken = a < rb;
            OP_BGEU:              e.taken = a >= rb;
            default:              e.taken = 1'b0;
        endcase
        e.taken      = e.taken && valid_i;
        e.target     = (op_i == OP_JIRL) ? a + imm_i : pc_i + imm_i;
        e.mem_addr   = a + imm_i;
        e.store_data = rb;
        mis = 1'b0;
        if (op_i == OP_LD_H || op_i == OP_ST_H) begin
            mis = e.mem_addr[0];
        end else if (op_i == OP_LD_W || op_i == OP_ST_W) begin
            mis = |e.mem_addr[1:0];
        end
        no_write    = op_i inside {OP_B, [OP_BEQ:OP_BGEU]};
        e.valid     = valid_i;
        e.we        = valid_i && rd_we_i && !no_write && !mis;
        e.rd_addr   = rd_addr_i;
        e.is_load   = valid_i && op_i inside {[OP_LD_B:OP_LD_W]};
        e.is_store  = valid_i && op_i inside {[OP_ST_B:OP_ST_W]};
        e.excp      = valid_i && mis;
        e.excp_code = mis ? EXCP_ALE : EXCP_NONE;
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH time %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Output register model with the same priority as the stage
    always @(posedge clk) begin
        if (reset_i || flush_i) begin
            exp_q.valid    = 1'b0;
            exp_q.we       = 1'b0;
            exp_q.is_load  = 1'b0;
            exp_q.is_store = 1'b0;
            exp_q.excp     = 1'b0;
        end else if (!stall_i) begin
            exp_q = predict_stage();
        end
    end

    always @(negedge clk) begin : check_outputs
        expect_t now;
        compare_value("valid_o", valid_o, exp_q.valid);
        compare_value("rd_we_o", rd_we_o, exp_q.we);
        compare_value("is_load_o", is_load_o, exp_q.is_load);
        compare_value("is_store_o", is_store_o, exp_q.is_store);
        compare_value("excp_o", excp_o, exp_q.excp);
        if (exp_q.valid) begin
            compare_value("rd_addr_o", rd_addr_o, exp_q.rd_addr);
            compare_value("rd_data_o", rd_data_o, exp_q.rd_data);
            compare_value("excp_code_o", excp_code_o, exp_q.excp_code);
            if (exp_q.is_load || exp_q.is_store) begin
                compare_value("mem_addr_o", mem_addr_o, exp_q.mem_addr);
            end
            if (exp_q.is_store) begin
                compare_value("store_data_o", store_data_o, exp_q.store_data);
            end
        end
        now = predict_stage();
        compare_value("branch_taken_o", branch_taken_o, now.taken);
        if (valid_i && now.is_ctrl) begin
            compare_value("branch_target_o", branch_target_o, now.target);
        end
    end

    // Boundary values show up often so signed and unsigned compares differ
    function automatic word_t pick_operand();
        case ($urandom_range(7, 0))
            0:       return 32'h8000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'h0000_0000;
            3:       return 32'hffff_ffff;
            default: return $urandom();
        endcase
    endfunction

    task automatic drive_random(input int op_lo, input int op_hi, input bit fwd_on,
                                input bit ctrl_on);
        ex_op_t op;
        op = ex_op_t'($urandom_range(op_hi, op_lo));
        @(posedge clk);
        valid_i       <= ($urandom_range(7, 0) != 0);
        op_i          <= op;
        use_imm_i     <= $urandom_range(1, 0);
        rs1_addr_i    <= fwd_on ? $urandom_range(3, 0) : $urandom_range(31, 0);
        rs2_addr_i    <= fwd_on ? $urandom_range(3, 0) : $urandom_range(31, 0);
        rs1_data_i    <= pick_operand();
        rs2_data_i    <= pick_operand();
        imm_i         <= (op >= OP_LD_B) ? word_t'($urandom_range(15, 0)) : pick_operand();
        pc_i          <= word_t'($urandom()) & 32'hffff_fffc;
        rd_addr_i     <= $urandom_range(31, 0);
        rd_we_i       <= (op < OP_ST_B) && ($urandom_range(3, 0) != 0);
        fwd_we_i      <= fwd_on ? $urandom_range(3, 0) : 0;
        fwd_addr_i[0] <= $urandom_range(3, 0);
        fwd_addr_i[1] <= $urandom_range(3, 0);
        fwd_data_i[0] <= pick_operand();
        fwd_data_i[1] <= pick_operand();
        stall_i       <= ctrl_on && ($urandom_range(3, 0) == 0);
        flush_i       <= ctrl_on && ($urandom_range(7, 0) == 0);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        valid_i  <= 1'b0;
        stall_i  <= 1'b0;
        flush_i  <= 1'b0;
        fwd_we_i <= '0;
    endtask

    task automatic run_test(input string name, input int op_lo, input int op_hi,
                            input bit fwd_on, input bit ctrl_on, input int cycles);
        int chk_start;
        int err_start;
        chk_start = checks;
        err_start = errors;
        repeat (cycles) drive_random(op_lo, op_hi, fwd_on, ctrl_on);
        drive_idle();
        repeat (2) @(posedge clk);
        $display("%-10s %0d checks, %0d mismatches", name, checks - chk_start,
                 errors - err_start);
    endtask

    // Reset lands on a valid instruction in flight
    task automatic reset_midrun();
        int err_start;
        err_start = errors;
        drive_random(0, 29, 1'b0, 1'b0);
        @(posedge clk);
        valid_i <= 1'b1;
        reset_i <= 1'b1;
        @(posedge clk);
        reset_i <= 1'b0;
        drive_idle();
        repeat (2) @(posedge clk);
        $display("%-10s %0d mismatches", "reset", errors - err_start);
    endtask

    initial begin
        void'($urandom(26225));
        reset_i    = 1'b1;
        valid_i    = 1'b0;
        op_i       = OP_ADD;
        use_imm_i  = 1'b0;
        rs1_addr_i = '0;
        rs2_addr_i = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        imm_i      = '0;
        pc_i       = '0;
        rd_addr_i  = '0;
        rd_we_i    = 1'b0;
        fwd_we_i   = '0;
        fwd_addr_i = '0;
        fwd_data_i = '0;
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        checks     = 0;
        errors     = 0;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        run_test("alu", OP_ADD, OP_PCADDU12I, 1'b0, 1'b0, N_ALU);
        run_test("forward", OP_ADD, OP_ST_W, 1'b1, 1'b0, N_FWD);
        run_test("branch", OP_B, OP_BGEU, 1'b1, 1'b0, N_BRANCH);
        run_test("memory", OP_LD_B, OP_ST_W, 1'b1, 1'b0, N_MEM);
        run_test("stall", OP_ADD, OP_ST_W, 1'b1, 1'b1, N_CTRL);
        reset_midrun();
        $display("Total: %0d checks, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WDOG_CYCLES * PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/ex_op_pkg.sv
hw/ex_data_pkg.sv
hw/ex_decode.sv
hw/ex_alu.sv
hw/ex_result.sv
hw/ex_stage.sv
tests/tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/ex_op_pkg.sv
      - hw/ex_data_pkg.sv
      - hw/ex_decode.sv
      - hw/ex_alu.sv
      - hw/ex_result.sv
      - hw/ex_stage.sv
      - target: test
        files:
          - tests/tb_ex_stage.sv
